/* soc_bus_pkg.sv */
// Bus widths, request and response types and the two views of an address
// Imported by every RTL module and by the testbench
package soc_bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One strobe per byte lane
  localparam int STRB_W = DATA_W / 8;

  // Request from a master, or from the interconnect to a slave
  typedef struct packed {
    logic              cyc;
    logic              we;
    logic [STRB_W-1:0] strb;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              ack;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Memory view of an address
  typedef struct packed {
    logic [3:0]  region;
    logic [3:0]  unused;
    logic [21:0] word;
    logic [1:0]  offset;
  } mem_view_t;

  // Device register view of an address
  typedef struct packed {
    logic [3:0]  region;
    logic [21:0] unused;
    logic [3:0]  reg_idx;
    logic [1:0]  offset;
  } dev_view_t;

  typedef union packed {
    mem_view_t mem;
    dev_view_t dev;
  } bus_addr_u;

  // Merge new data into an old word under byte strobes
  function automatic logic [DATA_W-1:0] apply_strb(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    int                b;
    res = old_word;
    for (b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

/* soc_dev_pkg.sv */
// Region codes, device register indices and status bit positions
// Imported by the interconnect, the device slaves and the testbench
package soc_dev_pkg;

  // Region codes, top nibble of the address
  localparam logic [3:0] REGION_MEM = 4'd0;
  localparam logic [3:0] REGION_KEY = 4'd1;
  localparam logic [3:0] REGION_DMA = 4'd2;

  // Keyboard registers
  localparam logic [3:0] KEY_DATA   = 4'd0;
  localparam logic [3:0] KEY_STATUS = 4'd1;

  localparam int KEY_READY_BIT   = 0;
  localparam int KEY_OVERRUN_BIT = 1;

  // DMA registers
  localparam logic [3:0] DMA_SRC    = 4'd0;
  localparam logic [3:0] DMA_DST    = 4'd1;
  localparam logic [3:0] DMA_LEN    = 4'd2;
  localparam logic [3:0] DMA_CTRL   = 4'd3;
  localparam logic [3:0] DMA_STATUS = 4'd4;

  localparam int DMA_BUSY_BIT = 0;
  localparam int DMA_DONE_BIT = 1;

  // Read value of any unmapped region
  localparam logic [31:0] EMPTY_DATA = 32'hBAD0_BAD0;

endpackage

/* wb_interconnect.sv */
// Shared bus with two masters, CPU first, and address decode to three slaves
// Unmapped regions are answered by a local responder
`timescale 1ns/1ps

module wb_interconnect import soc_bus_pkg::*, soc_dev_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic     clk,
  input  logic     rst_i,
  input  bus_req_t cpu_req_i,
  input  bus_req_t dma_req_i,
  output bus_rsp_t cpu_rsp_o,
  output bus_rsp_t dma_rsp_o,
  output bus_req_t mem_req_o,
  input  bus_rsp_t mem_rsp_i,
  output bus_req_t key_req_o,
  input  bus_rsp_t key_rsp_i,
  output bus_req_t dmar_req_o,
  input  bus_rsp_t dmar_rsp_i
);

  logic      locked_q;
  logic      owner_q;
  logic      sel_dma;
  bus_req_t  sel_req;
  bus_rsp_t  sel_rsp;
  bus_addr_u sel_addr;
  logic      hit_mem;
  logic      hit_key;
  logic      hit_dmar;
  logic      hit_none;
  logic      emp_ack_q;

  ////////////////////////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////////////////////////

  // Free bus goes to the CPU when it asks, else to the DMA
  assign sel_dma = locked_q ? owner_q : ~cpu_req_i.cyc;
  assign sel_req = sel_dma ? dma_req_i : cpu_req_i;

  // Grant is held for one transfer and released at its ack
  always_ff @(posedge clk) begin
    if (rst_i) begin
      locked_q <= 1'b0;
      owner_q  <= 1'b0;
    end else if (locked_q) begin
      if (sel_rsp.ack || !sel_req.cyc) begin
        locked_q <= 1'b0;
      end
    end else if (sel_req.cyc) begin
      locked_q <= 1'b1;
      owner_q  <= sel_dma;
    end
  end

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  assign sel_addr = sel_req.addr;
  assign hit_mem  = (sel_addr.dev.region == REGION_MEM);
  assign hit_key  = (sel_addr.dev.region == REGION_KEY);
  assign hit_dmar = (sel_addr.dev.region == REGION_DMA);
  assign hit_none = ~(hit_mem | hit_key | hit_dmar);

  always_comb begin
    mem_req_o      = sel_req;
    mem_req_o.cyc  = sel_req.cyc & hit_mem;
    key_req_o      = sel_req;
    key_req_o.cyc  = sel_req.cyc & hit_key;
    dmar_req_o     = sel_req;
    dmar_req_o.cyc = sel_req.cyc & hit_dmar;
  end

  // Empty region responder, writes are dropped
  always_ff @(posedge clk) begin
    if (rst_i) begin
      emp_ack_q <= 1'b0;
    end else begin
      emp_ack_q <= sel_req.cyc & hit_none & ~emp_ack_q;
    end
  end

  always_comb begin
    if (hit_mem) begin
      sel_rsp = mem_rsp_i;
    end else if (hit_key) begin
      sel_rsp = key_rsp_i;
    end else if (hit_dmar) begin
      sel_rsp = dmar_rsp_i;
    end else begin
      sel_rsp = '{ack: emp_ack_q, rdata: EMPTY_DATA};
    end
  end

  // Only the owner sees the ack
  assign cpu_rsp_o = '{ack: sel_rsp.ack & ~sel_dma, rdata: sel_rsp.rdata};
  assign dma_rsp_o = '{ack: sel_rsp.ack & sel_dma, rdata: sel_rsp.rdata};

  // Acks only arrive while a transfer holds the grant
  a_ack_owner: assert property (@(posedge clk) disable iff (rst_i)
    (cpu_rsp_o.ack || dma_rsp_o.ack) |-> locked_q);

  a_mem_range: assert property (@(posedge clk) disable iff (rst_i)
    mem_req_o.cyc |-> (sel_addr.mem.word < MEM_WORDS));

endmodule

/* main_mem.sv */
// Word-wide main memory with byte-strobe writes
// Read data and ack are registered, one cycle after the request
`timescale 1ns/1ps

module main_mem import soc_bus_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic     clk,
  input  logic     rst_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;
  logic              take;
  logic [AW-1:0]     idx;
  bus_addr_u         addr;

  assign addr = req_i.addr;
  assign idx  = addr.mem.word[AW-1:0];
  // New request only while no ack is pending
  assign take = req_i.cyc & ~ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rdata_q <= mem[idx];
      if (req_i.we) begin
        mem[idx] <= apply_strb(mem[idx], req_i.wdata, req_i.strb);
      end
    end
  end

  assign rsp_o = '{ack: ack_q, rdata: rdata_q};

  // Request stays in place through its ack cycle
  a_req_held: assert property (@(posedge clk) disable iff (rst_i)
    rsp_o.ack |-> req_i.cyc && $stable(req_i.addr) && $stable(req_i.we));

endmodule

/* keyboard_port.sv */
// Keyboard slave with a one-entry key-code buffer
// Status shows ready and overrun, a write to status clears overrun
`timescale 1ns/1ps

module keyboard_port import soc_bus_pkg::*, soc_dev_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  bus_req_t   req_i,
  output bus_rsp_t   rsp_o,
  input  logic [7:0] key_code_i,
  input  logic       key_valid_i
);

  bus_addr_u         addr;
  logic              take;
  logic              rd_data;
  logic              wr_status;
  logic              ack_q;
  logic              ready_q;
  logic              overrun_q;
  logic [7:0]        code_q;
  logic [DATA_W-1:0] rd_val;
  logic [DATA_W-1:0] rdata_q;

  assign addr      = req_i.addr;
  assign take      = req_i.cyc & ~ack_q;
  assign rd_data   = take & ~req_i.we & (addr.dev.reg_idx == KEY_DATA);
  assign wr_status = take & req_i.we & (addr.dev.reg_idx == KEY_STATUS);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q     <= 1'b0;
      ready_q   <= 1'b0;
      overrun_q <= 1'b0;
    end else begin
      ack_q <= take;
      // A new key wins over a read in the same cycle
      if (key_valid_i) begin
        ready_q <= 1'b1;
      end else if (rd_data) begin
        ready_q <= 1'b0;
      end
      if (key_valid_i && ready_q) begin
        overrun_q <= 1'b1;
      end else if (wr_status) begin
        overrun_q <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_val = '0;
    if (addr.dev.reg_idx == KEY_DATA) begin
      rd_val[7:0] = code_q;
    end else if (addr.dev.reg_idx == KEY_STATUS) begin
      rd_val[KEY_READY_BIT]   = ready_q;
      rd_val[KEY_OVERRUN_BIT] = overrun_q;
    end
  end

  always_ff @(posedge clk) begin
    if (key_valid_i) begin
      code_q <= key_code_i;
    end
    if (take) begin
      rdata_q <= rd_val;
    end
  end

  assign rsp_o = '{ack: ack_q, rdata: rdata_q};

endmodule

/* dma_regs.sv */
// DMA register block on the bus: source, destination, length, control, status
// Makes the start pulse and keeps the done flag and interrupt level
`timescale 1ns/1ps

module dma_regs import soc_bus_pkg::*, soc_dev_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  bus_req_t          req_i,
  output bus_rsp_t          rsp_o,
  input  logic              busy_i,
  input  logic              done_i,
  input  logic              irq_clear_i,
  output logic              start_o,
  output logic [ADDR_W-1:0] src_o,
  output logic [ADDR_W-1:0] dst_o,
  output logic [DATA_W-1:0] len_o,
  output logic              irq_o
);

  bus_addr_u         addr;
  logic [3:0]        idx;
  logic              take;
  logic              wr;
  logic              ack_q;
  logic              start_q;
  logic              done_q;
  logic              irq_q;
  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] len_q;
  logic [DATA_W-1:0] rd_val;
  logic [DATA_W-1:0] rdata_q;

  assign addr = req_i.addr;
  assign idx  = addr.dev.reg_idx;
  assign take = req_i.cyc & ~ack_q;
  assign wr   = take & req_i.we;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      ack_q <= take;
      // Start is dropped while a copy runs
      start_q <= wr & (idx == DMA_CTRL) & req_i.strb[0] & req_i.wdata[0] & ~busy_i;
      if (done_i) begin
        done_q <= 1'b1;
        irq_q  <= 1'b1;
      end else if (start_q) begin
        done_q <= 1'b0;
        irq_q  <= 1'b0;
      end else if (irq_clear_i) begin
        irq_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr && idx == DMA_SRC) begin
      src_q <= apply_strb(src_q, req_i.wdata, req_i.strb);
    end
    if (wr && idx == DMA_DST) begin
      dst_q <= apply_strb(dst_q, req_i.wdata, req_i.strb);
    end
    if (wr && idx == DMA_LEN) begin
      len_q <= apply_strb(len_q, req_i.wdata, req_i.strb);
    end
    if (take) begin
      rdata_q <= rd_val;
    end
  end

  always_comb begin
    rd_val = '0;
    case (idx)
      DMA_SRC: rd_val = src_q;
      DMA_DST: rd_val = dst_q;
      DMA_LEN: rd_val = len_q;
      DMA_STATUS: begin
        rd_val[DMA_BUSY_BIT] = busy_i;
        rd_val[DMA_DONE_BIT] = done_q;
      end
      default: rd_val = '0;
    endcase
  end

  assign rsp_o   = '{ack: ack_q, rdata: rdata_q};
  assign start_o = start_q;
  assign src_o   = src_q;
  assign dst_o   = dst_q;
  assign len_o   = len_q;
  assign irq_o   = irq_q;

endmodule

/* dma_fsm.sv */
// DMA bus master: one read then one write per word until the count runs out
// Pulses step at each write ack and done when the copy ends
`timescale 1ns/1ps

module dma_fsm import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              start_i,
  input  logic              last_i,
  input  logic              empty_i,
  input  logic [ADDR_W-1:0] src_addr_i,
  input  logic [ADDR_W-1:0] dst_addr_i,
  output bus_req_t          req_o,
  input  bus_rsp_t          rsp_i,
  output logic              step_o,
  output logic              busy_o,
  output logic              done_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_WRITE,
    S_FINISH
  } state_t;

  state_t            state_q;
  state_t            state_d;
  logic [DATA_W-1:0] data_q;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        // Zero length skips the bus entirely
        if (start_i) begin
          state_d = empty_i ? S_FINISH : S_READ;
        end
      end
      S_READ: begin
        if (rsp_i.ack) begin
          state_d = S_WRITE;
        end
      end
      S_WRITE: begin
        if (rsp_i.ack) begin
          state_d = last_i ? S_FINISH : S_READ;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word in flight between the read and the write
  always_ff @(posedge clk) begin
    if (state_q == S_READ && rsp_i.ack) begin
      data_q <= rsp_i.rdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus request and status
  ////////////////////////////////////////////////////////////

  always_comb begin
    req_o.cyc   = (state_q == S_READ) || (state_q == S_WRITE);
    req_o.we    = (state_q == S_WRITE);
    req_o.strb  = '1;
    req_o.addr  = (state_q == S_WRITE) ? dst_addr_i : src_addr_i;
    req_o.wdata = data_q;
  end

  assign step_o = (state_q == S_WRITE) & rsp_i.ack;
  assign busy_o = (state_q != S_IDLE);
  assign done_o = (state_q == S_FINISH);

  // No ack may reach the DMA while it has no request out
  a_no_stray_ack: assert property (@(posedge clk) disable iff (rst_i)
    !req_o.cyc |-> !rsp_i.ack);

endmodule

/* dma_counter.sv */
// DMA address counters and remaining word count
// Loaded on start, advanced one word at each step
`timescale 1ns/1ps

module dma_counter import soc_bus_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              start_i,
  input  logic              step_i,
  input  logic [ADDR_W-1:0] src_i,
  input  logic [ADDR_W-1:0] dst_i,
  input  logic [DATA_W-1:0] len_i,
  output logic [ADDR_W-1:0] src_addr_o,
  output logic [ADDR_W-1:0] dst_addr_o,
  output logic              last_o,
  output logic              empty_o
);

  logic [ADDR_W-1:0] src_q;
  logic [ADDR_W-1:0] dst_q;
  logic [DATA_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= len_i;
    end else if (step_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Byte addresses, one word per step
  always_ff @(posedge clk) begin
    if (start_i) begin
      src_q <= src_i;
      dst_q <= dst_i;
    end else if (step_i) begin
      src_q <= src_q + ADDR_W'(STRB_W);
      dst_q <= dst_q + ADDR_W'(STRB_W);
    end
  end

  assign src_addr_o = src_q;
  assign dst_addr_o = dst_q;
  assign last_o     = (cnt_q == DATA_W'(1));
  // Valid in the start cycle, before the count is loaded
  assign empty_o    = (len_i == '0);

endmodule

/* soc_top.sv */
// SoC top: bus interconnect, main memory, keyboard and the DMA engine
// The CPU is an external master port
`timescale 1ns/1ps

module soc_top import soc_bus_pkg::*; #(
  parameter int MEM_WORDS = 1024
) (
  input  logic       clk,
  input  logic       rst_i,
  input  bus_req_t   cpu_req_i,
  output bus_rsp_t   cpu_rsp_o,
  input  logic [7:0] key_code_i,
  input  logic       key_valid_i,
  input  logic       dma_irq_clear_i,
  output logic       dma_irq_o
);

  bus_req_t          dma_req;
  bus_rsp_t          dma_rsp;
  bus_req_t          mem_req;
  bus_rsp_t          mem_rsp;
  bus_req_t          key_req;
  bus_rsp_t          key_rsp;
  bus_req_t          dmar_req;
  bus_rsp_t          dmar_rsp;
  logic              dma_start;
  logic              dma_busy;
  logic              dma_done;
  logic              dma_step;
  logic              dma_last;
  logic              dma_empty;
  logic [ADDR_W-1:0] dma_src;
  logic [ADDR_W-1:0] dma_dst;
  logic [DATA_W-1:0] dma_len;
  logic [ADDR_W-1:0] dma_src_addr;
  logic [ADDR_W-1:0] dma_dst_addr;

  ////////////////////////////////////////////////////////////
  // Bus and slaves
  ////////////////////////////////////////////////////////////

  wb_interconnect #(
    .MEM_WORDS (MEM_WORDS)
  ) wb_interconnect_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .cpu_req_i  (cpu_req_i),
    .dma_req_i  (dma_req),
    .cpu_rsp_o  (cpu_rsp_o),
    .dma_rsp_o  (dma_rsp),
    .mem_req_o  (mem_req),
    .mem_rsp_i  (mem_rsp),
    .key_req_o  (key_req),
    .key_rsp_i  (key_rsp),
    .dmar_req_o (dmar_req),
    .dmar_rsp_i (dmar_rsp)
  );

  main_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) main_mem_inst (
    .clk   (clk),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

  keyboard_port keyboard_port_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (key_req),
    .rsp_o       (key_rsp),
    .key_code_i  (key_code_i),
    .key_valid_i (key_valid_i)
  );

  ////////////////////////////////////////////////////////////
  // DMA engine
  ////////////////////////////////////////////////////////////

  dma_regs dma_regs_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_i       (dmar_req),
    .rsp_o       (dmar_rsp),
    .busy_i      (dma_busy),
    .done_i      (dma_done),
    .irq_clear_i (dma_irq_clear_i),
    .start_o     (dma_start),
    .src_o       (dma_src),
    .dst_o       (dma_dst),
    .len_o       (dma_len),
    .irq_o       (dma_irq_o)
  );

  dma_fsm dma_fsm_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .start_i    (dma_start),
    .last_i     (dma_last),
    .empty_i    (dma_empty),
    .src_addr_i (dma_src_addr),
    .dst_addr_i (dma_dst_addr),
    .req_o      (dma_req),
    .rsp_i      (dma_rsp),
    .step_o     (dma_step),
    .busy_o     (dma_busy),
    .done_o     (dma_done)
  );

  dma_counter dma_counter_inst (
    .clk        (clk),
    .rst_i      (rst_i),
    .start_i    (dma_start),
    .step_i     (dma_step),
    .src_i      (dma_src),
    .dst_i      (dma_dst),
    .len_i      (dma_len),
    .src_addr_o (dma_src_addr),
    .dst_addr_o (dma_dst_addr),
    .last_o     (dma_last),
    .empty_o    (dma_empty)
  );

endmodule

/* tb_soc_tasks.svh */
// CPU master port transfers on the shared bus, included inside the testbench module
// Every transfer waits for ack under its own timeout

localparam int ACK_TIMEOUT = 100;

// One request held until ack, then cyc dropped on the next edge
task automatic run_transfer(
  input  logic        we,
  input  logic [31:0] addr,
  input  logic [31:0] wdata,
  input  logic [3:0]  strb,
  output logic [31:0] rdata,
  output int          lat
);
  int   n;
  logic seen;
  n    = 0;
  seen = 1'b0;
  @(posedge clk);
  cpu_req.cyc   <= 1'b1;
  cpu_req.we    <= we;
  cpu_req.strb  <= strb;
  cpu_req.addr  <= addr;
  cpu_req.wdata <= wdata;
  // Ack is sampled mid-cycle, away from the clock edge
  while (!seen && n < ACK_TIMEOUT) begin
    @(negedge clk);
    if (cpu_rsp.ack) begin
      seen = 1'b1;
    end else begin
      n++;
    end
  end
  rdata = cpu_rsp.rdata;
  lat   = n;
  @(posedge clk);
  cpu_req.cyc <= 1'b0;
  cpu_req.we  <= 1'b0;
  if (!seen) begin
    other_errs++;
    $display("Timeout: no ack for CPU %s at address 0x%08h", we ? "write" : "read", addr);
  end
endtask

task automatic cpu_write(
  input logic [31:0] addr,
  input logic [31:0] data,
  input logic [3:0]  strb
);
  logic [31:0] unused_rd;
  int          unused_lat;
  run_transfer(1'b1, addr, data, strb, unused_rd, unused_lat);
endtask

// Lat counts the cycles spent waiting after the first one
task automatic cpu_read(
  input  logic [31:0] addr,
  output logic [31:0] data,
  output int          lat
);
  run_transfer(1'b0, addr, 32'h0, 4'hF, data, lat);
endtask

/* tb_soc.sv */
// Testbench for the SoC bus: memory, keyboard, DMA copy, contention and empty region
// Reads are checked against a shadow memory by a separate compare process
`timescale 1ns/1ps

module tb_soc import soc_bus_pkg::*, soc_dev_pkg::*; ();

  localparam int MEM_WORDS   = 1024;
  localparam int FILL_WORDS  = 512;
  localparam int IRQ_TIMEOUT = 2000;

  logic       clk;
  logic       rst_i;
  bus_req_t   cpu_req;
  bus_rsp_t   cpu_rsp;
  logic [7:0] key_code;
  logic       key_valid;
  logic       irq_clear;
  logic       dma_irq;

  logic [31:0] shadow [MEM_WORDS];
  string       name_q [$];
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  int          mismatch_errs = 0;
  int          other_errs = 0;

  `include "tb_soc_tasks.svh"

  soc_top #(
    .MEM_WORDS (MEM_WORDS)
  ) soc_top_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .cpu_req_i       (cpu_req),
    .cpu_rsp_o       (cpu_rsp),
    .key_code_i      (key_code),
    .key_valid_i     (key_valid),
    .dma_irq_clear_i (irq_clear),
    .dma_irq_o       (dma_irq)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Byte lanes from the new word where the strobe is set
  function automatic logic [31:0] merge_bytes(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  strb
  );
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  // Forward word copy, same order as the DMA
  function automatic void model_copy(input int src, input int dst, input int len);
    int i;
    for (i = 0; i < len; i++) begin
      shadow[dst + i] = shadow[src + i];
    end
  endfunction

  function automatic logic [31:0] fill_value(input int idx);
    logic [15:0] w;
    w = 16'(idx);
    return {w, ~w} ^ 32'hC3A5_0F1E;
  endfunction

  function automatic logic [31:0] mem_addr(input int idx);
    return {8'h00, 22'(idx), 2'b00};
  endfunction

  function automatic logic [31:0] reg_addr(input logic [3:0] region, input logic [3:0] idx);
    return {region, 22'h0, idx, 2'b00};
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic expect_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  initial begin : compare_proc
    string       name;
    logic [31:0] got;
    logic [31:0] exp;
    forever begin
      @(negedge clk);
      while (got_q.size() > 0) begin
        name = name_q.pop_front();
        got  = got_q.pop_front();
        exp  = exp_q.pop_front();
        if (got !== exp) begin
          mismatch_errs++;
          $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
      end
    end
  end

  task automatic drain_checks();
    int n;
    n = 0;
    while (got_q.size() > 0 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (got_q.size() > 0) begin
      other_errs++;
      $display("Compare process left %0d results unchecked", got_q.size());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  task automatic pulse_key(input logic [7:0] code);
    @(posedge clk);
    key_code  <= code;
    key_valid <= 1'b1;
    @(posedge clk);
    key_valid <= 1'b0;
  endtask

  // Interrupt must be low one cycle after the clear pulse
  task automatic clear_irq();
    @(posedge clk);
    irq_clear <= 1'b1;
    @(posedge clk);
    irq_clear <= 1'b0;
    @(negedge clk);
    expect_value("dma_irq_o", {31'h0, dma_irq}, 32'h0);
  endtask

  task automatic wait_irq(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (dma_irq !== 1'b1 && n < limit);
    if (dma_irq !== 1'b1) begin
      other_errs++;
      $display("Timeout: dma_irq_o did not rise within %0d cycles", limit);
    end
  endtask

  task automatic start_dma(input int src, input int dst, input int len);
    cpu_write(reg_addr(REGION_DMA, DMA_SRC), mem_addr(src), 4'hF);
    cpu_write(reg_addr(REGION_DMA, DMA_DST), mem_addr(dst), 4'hF);
    cpu_write(reg_addr(REGION_DMA, DMA_LEN), 32'(len), 4'hF);
    cpu_write(reg_addr(REGION_DMA, DMA_CTRL), 32'h1, 4'hF);
  endtask

  task automatic read_words(input int first, input int count);
    logic [31:0] rd;
    int          lat;
    int          i;
    for (i = first; i < first + count; i++) begin
      cpu_read(mem_addr(i), rd, lat);
      expect_value($sformatf("cpu_rsp_o.rdata mem[%0d]", i), rd, shadow[i]);
    end
  endtask

  task automatic read_dma_status();
    logic [31:0] rd;
    int          lat;
    cpu_read(reg_addr(REGION_DMA, DMA_STATUS), rd, lat);
    expect_value("cpu_rsp_o.rdata DMA STATUS", rd, 32'h1 << DMA_DONE_BIT);
  endtask

  ////////////////////////////////////////////////////////////
  // Behaviors
  ////////////////////////////////////////////////////////////

  task automatic fill_memory();
    int i;
    for (i = 0; i < FILL_WORDS; i++) begin
      shadow[i] = fill_value(i);
      cpu_write(mem_addr(i), shadow[i], 4'hF);
    end
  endtask

  task automatic strobe_write_pass();
    logic [31:0] data;
    logic [31:0] rd;
    logic [3:0]  strb;
    int          idx;
    int          lat;
    int          n;
    for (n = 0; n < 40; n++) begin
      idx  = int'($urandom % 64);
      data = $urandom;
      strb = 4'($urandom);
      shadow[idx] = merge_bytes(shadow[idx], data, strb);
      cpu_write(mem_addr(idx), data, strb);
    end
    read_words(0, 64);
    // Idle bus answers one cycle after the request
    cpu_read(mem_addr(10), rd, lat);
    expect_value("cpu_rsp_o.ack latency", 32'(lat), 32'h1);
  endtask

  task automatic keyboard_buffer();
    logic [31:0] rd;
    int          lat;
    pulse_key(8'h3C);
    cpu_read(reg_addr(REGION_KEY, KEY_STATUS), rd, lat);
    expect_value("cpu_rsp_o.rdata KEY STATUS", rd, 32'h1 << KEY_READY_BIT);
    cpu_read(reg_addr(REGION_KEY, KEY_DATA), rd, lat);
    expect_value("cpu_rsp_o.rdata KEY DATA", rd, 32'h3C);
    cpu_read(reg_addr(REGION_KEY, KEY_STATUS), rd, lat);
    expect_value("cpu_rsp_o.rdata KEY STATUS", rd, 32'h0);
    // Second key lands on a full buffer
    pulse_key(8'h11);
    pulse_key(8'h22);
    cpu_read(reg_addr(REGION_KEY, KEY_STATUS), rd, lat);
    expect_value("cpu_rsp_o.rdata KEY STATUS", rd,
                 (32'h1 << KEY_READY_BIT) | (32'h1 << KEY_OVERRUN_BIT));
    cpu_read(reg_addr(REGION_KEY, KEY_DATA), rd, lat);
    expect_value("cpu_rsp_o.rdata KEY DATA", rd, 32'h22);
    cpu_read(reg_addr(REGION_KEY, KEY_STATUS), rd, lat);
    expect_value("cpu_rsp_o.rdata KEY STATUS", rd, 32'h1 << KEY_OVERRUN_BIT);
    cpu_write(reg_addr(REGION_KEY, KEY_STATUS), 32'h0, 4'hF);
    cpu_read(reg_addr(REGION_KEY, KEY_STATUS), rd, lat);
    expect_value("cpu_rsp_o.rdata KEY STATUS", rd, 32'h0);
  endtask

  task automatic copy_block();
    clear_irq();
    start_dma(0, 128, 32);
    wait_irq(IRQ_TIMEOUT);
    model_copy(0, 128, 32);
    read_words(128, 32);
    read_dma_status();
  endtask

  task automatic copy_during_reads();
    logic [31:0] rd;
    int          lat;
    int          max_lat;
    int          i;
    max_lat = 0;
    clear_irq();
    start_dma(64, 192, 64);
    for (i = 300; i < 316; i++) begin
      cpu_read(mem_addr(i), rd, lat);
      expect_value($sformatf("cpu_rsp_o.rdata mem[%0d]", i), rd, shadow[i]);
      if (lat > max_lat) begin
        max_lat = lat;
      end
    end
    wait_irq(IRQ_TIMEOUT);
    model_copy(64, 192, 64);
    read_words(192, 64);
    if (max_lat < 2) begin
      other_errs++;
      $display("CPU reads never waited behind the DMA during the copy");
    end
  endtask

  task automatic zero_length_copy();
    clear_irq();
    start_dma(0, 400, 0);
    wait_irq(IRQ_TIMEOUT);
    read_words(400, 2);
    read_dma_status();
  endtask

  task automatic empty_region_access();
    logic [31:0] rd;
    int          lat;
    cpu_read(reg_addr(4'h5, 4'h0), rd, lat);
    expect_value("cpu_rsp_o.rdata region 5", rd, 32'hBAD0_BAD0);
    // Low bits alias memory word 4, which must stay as it was
    cpu_write(32'h5000_0010, 32'hDEAD_BEEF, 4'hF);
    read_words(4, 1);
    cpu_read(32'h5000_0010, rd, lat);
    expect_value("cpu_rsp_o.rdata region 5", rd, 32'hBAD0_BAD0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(2));
    rst_i     = 1'b1;
    cpu_req   = '0;
    key_code  = 8'h00;
    key_valid = 1'b0;
    irq_clear = 1'b0;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;

    fill_memory();
    strobe_write_pass();
    keyboard_buffer();
    copy_block();
    copy_during_reads();
    zero_length_copy();
    empty_region_access();

    drain_checks();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+.
soc_bus_pkg.sv
soc_dev_pkg.sv
wb_interconnect.sv
main_mem.sv
keyboard_port.sv
dma_regs.sv
dma_fsm.sv
dma_counter.sv
soc_top.sv
tb_soc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the SoC testbench with Verilator, run it and judge the log

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc \
  -f filelist.f -o tb_soc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
